/* vlog.f */
rtl/msx_frame_pkg.sv
rtl/apb_status_regs.sv
rtl/video_scale_ctrl.sv
rtl/sd_activity.sv
rtl/cassette_path.sv
rtl/msx_frame_top.sv
testbench/msx_frame_checker.sv
testbench/tb_msx_frame.sv

/* Bender.yml */
package:
  name: msx_frame

sources:
  - files:
      - rtl/msx_frame_pkg.sv
      - rtl/apb_status_regs.sv
      - rtl/video_scale_ctrl.sv
      - rtl/sd_activity.sv
      - rtl/cassette_path.sv
      - rtl/msx_frame_top.sv
  - target: test
    files:
      - testbench/msx_frame_checker.sv
      - testbench/tb_msx_frame.sv

/* testbench/tb_msx_frame.sv */
`timescale 1ns/1ps

module tb_msx_frame;

   localparam int          n_rows     = 26;
   localparam logic [31:0] act_cycles = 32'd64;

   localparam logic [2:0] k_reg = 3'd0;
   localparam logic [2:0] k_vid = 3'd1;
   localparam logic [2:0] k_sd  = 3'd2;
   localparam logic [2:0] k_act = 3'd3;
   localparam logic [2:0] k_cas = 3'd4;
   localparam logic [2:0] k_ddr = 3'd5;

   // One stimulus row; aux is the read address or the HDMI size or a wait
   typedef struct packed {
      logic [2:0]  kind;
      logic        wr;
      logic [7:0]  addr;
      logic [31:0] wdata;
      logic [23:0] aux;
      logic [7:0]  arg;
      logic [63:0] exp_val;
   } row_t;

   logic        clk21m, reset, psel, penable, pwrite, pready, pslverr;
   logic [7:0]  paddr;
   logic [31:0] pwdata, prdata;
   logic        forced_scandoubler, hq2x, scandoubler;
   logic [11:0] hdmi_width, hdmi_height, video_arx, video_ary, crop_size;
   logic [1:0]  vga_sl, led_disk;
   logic [2:0]  scale_sel;
   logic        img_mounted;
   logic [63:0] img_size;
   logic        spi_sck, spi_mosi, sd_miso, vsd_miso, spi_miso;
   logic        sd_cs, sd_sck, sd_mosi, vsd_sel, led_user;
   logic        ioctl_download, motor, cas_dout, tape_adc, tape_adc_act;
   logic [15:0] ioctl_index;
   logic        play, rewind, cas_audio_in;
   logic        dl_ddr_req, dl_ddr_rd, cas_ddr_rd, ddr_rd, core_reset;
   logic [27:0] dl_ddr_addr, cas_ddr_addr, ddr_addr;

   // Checker handshake
   logic        check, done, timed_out;
   logic [2:0]  kind;
   logic [63:0] exp_word;
   int          test_id, fail_count, tests_done;

   row_t rows [n_rows];
   int   n_filled = 0;
   int   seed = 37848;

   msx_frame_top #(.sd_act_cycles(act_cycles)) msx_frame_top_inst (.*);

   msx_frame_checker #(.max_cycles(n_rows * 40 + 400)) checker_inst (.*);

   initial begin
      clk21m = 1'b0;
      forever #5 clk21m = ~clk21m;
   end

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk21m);
      #1;
   endtask

   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
      psel = 1'b1;
      pwrite = 1'b1;
      paddr = addr;
      pwdata = data;
      wait_cycles(1);
      penable = 1'b1;
      wait_cycles(1);
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
   endtask

   // Checker samples prdata and pslverr in the access phase
   task automatic apb_read_check(input logic [7:0] addr);
      psel = 1'b1;
      paddr = addr;
      wait_cycles(1);
      penable = 1'b1;
      check = 1'b1;
      wait_cycles(1);
      psel = 1'b0;
      penable = 1'b0;
      check = 1'b0;
   endtask

   task automatic add_row(input logic [2:0] k, input logic wr, input logic [7:0] addr,
                          input logic [31:0] wdata, input logic [23:0] aux,
                          input logic [7:0] arg, input logic [63:0] expv);
      rows[n_filled] = {k, wr, addr, wdata, aux, arg, expv};
      n_filled = n_filled + 1;
   endtask

   function automatic logic [63:0] pack_video(input logic [2:0] ssel, input logic [1:0] sl,
                                              input logic hq, input logic sd,
                                              input logic [11:0] crop, input logic [11:0] arx,
                                              input logic [11:0] ary);
      return {21'd0, ssel, sl, hq, sd, crop, arx, ary};
   endfunction

   // ===================================================================
   // Stimulus table
   // ===================================================================
   task automatic build_table();
      logic [7:0]  va;
      logic [7:0]  ta;
      logic [7:0]  ca;
      logic [7:0]  bad;
      logic [31:0] rnd;
      va = msx_frame_pkg::reg_video_addr;
      ta = msx_frame_pkg::reg_tape_addr;
      ca = msx_frame_pkg::reg_ctrl_addr;
      rnd = $random(seed);
      // Upper nibble nonzero keeps it off the map
      bad = {rnd[7:4] | 4'h1, rnd[3:0]};
      // Register rows: pready at bit 34, core_reset at 33, pslverr at 32
      add_row(k_reg, 1'b1, va, 32'h1234_56b5, {16'd0, va}, 8'h0, 64'h4_0000_00b5);
      add_row(k_reg, 1'b1, ta, 32'h0000_0003, {16'd0, ta}, 8'h0, 64'h4_0000_0001);
      add_row(k_reg, 1'b1, bad, rnd, {16'd0, bad}, 8'h0, 64'h5_0000_0000);
      add_row(k_reg, 1'b0, 8'h0, 32'h0, {16'd0, va}, 8'h0, 64'h4_0000_00b5);
      add_row(k_reg, 1'b0, 8'h0, 32'h0, {16'd0, ta}, 8'h0, 64'h4_0000_0001);
      // Eject holds the core reset one cycle past its pulse
      add_row(k_reg, 1'b1, ca, 32'h0000_0002, {16'd0, ca}, 8'h0, 64'h6_0000_0000);
      // Video rows: vcrop at bit 7, scale at 6:5, fx at 4:2, ar at 1:0
      add_row(k_vid, 1'b1, va, 32'h80, {12'd1920, 12'd1080}, 8'h0,
              pack_video(3'd0, 2'd0, 1'b0, 1'b0, 12'd216, 12'd400, 12'd300));
      add_row(k_vid, 1'b1, va, 32'h80, {12'd1024, 12'd600}, 8'h0,
              pack_video(3'd0, 2'd0, 1'b0, 1'b0, 12'd200, 12'd340, 12'd300));
      add_row(k_vid, 1'b1, va, 32'h82, {12'd1440, 12'd1440}, 8'h0,
              pack_video(3'd0, 2'd0, 1'b0, 1'b0, 12'd240, 12'd1, 12'd0));
      add_row(k_vid, 1'b1, va, 32'h93, {12'd640, 12'd480}, 8'h0,
              pack_video(3'd0, 2'd2, 1'b0, 1'b1, 12'd0, 12'd2, 12'd0));
      add_row(k_vid, 1'b1, va, 32'h45, {12'd1920, 12'd1080}, 8'h0,
              pack_video(3'd2, 2'd0, 1'b1, 1'b1, 12'd0, 12'd0, 12'd0));
      add_row(k_vid, 1'b1, va, 32'h0c, {12'd1920, 12'd1080}, 8'h0,
              pack_video(3'd0, 2'd1, 1'b0, 1'b1, 12'd0, 12'd400, 12'd300));
      // SD arg is spi_mosi, image nonzero, spi_sck, sd_miso, vsd_miso
      add_row(k_sd, 1'b0, 8'h0, 32'h0, 24'd0, 8'b11101, 64'b110101);
      add_row(k_sd, 1'b0, 8'h0, 32'h0, 24'd0, 8'b01110, 64'b110100);
      add_row(k_sd, 1'b0, 8'h0, 32'h0, 24'd0, 8'b10110, 64'b001011);
      add_row(k_act, 1'b0, 8'h0, 32'h0, 24'd0, 8'h1, 64'b11);
      add_row(k_act, 1'b0, 8'h0, 32'h0, act_cycles[23:0] + 24'd8, 8'h0, 64'b10);
      // Cassette arg is adc_act, adc, cas_dout, motor, download
      add_row(k_cas, 1'b0, 8'h0, 32'h0, 24'd0, 8'b00101, 64'b101);
      add_row(k_cas, 1'b0, 8'h0, 32'h0, 24'd0, 8'b00000, 64'b010);
      add_row(k_cas, 1'b1, ta, 32'h0, 24'd0, 8'b11010, 64'b001);
      add_row(k_cas, 1'b0, 8'h0, 32'h0, 24'd0, 8'b01000, 64'b010);
      add_row(k_cas, 1'b1, ca, 32'h1, 24'd0, 8'b11000, 64'b001);
      // Downloader requests and owns the port on even rows
      for (int i = 0; i < 4; i++) begin
         add_row(k_ddr, 1'b0, 8'h0, 32'h0, 24'd0, {7'd0, ~i[0]}, {63'd0, ~i[0]});
      end
   endtask

   task automatic apply_row(input row_t r);
      logic [31:0] rnd_hi;
      logic [31:0] rnd_lo;
      kind = r.kind;
      exp_word = r.exp_val;
      if (r.wr) apb_write(r.addr, r.wdata);
      case (r.kind)
         k_reg: apb_read_check(r.aux[7:0]);
         k_vid: {hdmi_width, hdmi_height} = r.aux;
         k_sd: begin
            rnd_hi = $random(seed);
            rnd_lo = $random(seed);
            spi_mosi = r.arg[4];
            spi_sck = r.arg[2];
            sd_miso = r.arg[1];
            vsd_miso = r.arg[0];
            img_size = r.arg[3] ? ({rnd_hi, rnd_lo} | 64'd1) : 64'd0;
            img_mounted = 1'b1;
            wait_cycles(1);
            img_mounted = 1'b0;
         end
         k_act: begin
            if (r.arg[0]) begin
               repeat (3) begin
                  spi_mosi = ~spi_mosi;
                  wait_cycles(1);
               end
            end else begin
               wait_cycles(r.aux);
            end
         end
         k_cas: begin
            ioctl_index = 16'h0105;
            {tape_adc_act, tape_adc, cas_dout, motor, ioctl_download} = r.arg[4:0];
         end
         default: begin
            rnd_hi = $random(seed);
            rnd_lo = $random(seed);
            dl_ddr_req = r.arg[0];
            dl_ddr_addr = rnd_hi[27:0];
            cas_ddr_addr = rnd_lo[27:0];
            // Opposite read strobes tell the two sides apart
            dl_ddr_rd = rnd_hi[31];
            cas_ddr_rd = ~rnd_hi[31];
            exp_word = r.exp_val[0] ? {35'd0, dl_ddr_rd, dl_ddr_addr}
                                    : {35'd0, cas_ddr_rd, cas_ddr_addr};
         end
      endcase
      if (r.kind != k_reg) begin
         wait_cycles(4);
         check = 1'b1;
         wait_cycles(1);
         check = 1'b0;
      end
   endtask

   initial begin
      reset = 1'b1;
      {psel, penable, pwrite, paddr, pwdata} = '0;
      {forced_scandoubler, hdmi_width, hdmi_height} = '0;
      {img_mounted, img_size, spi_sck, spi_mosi, sd_miso, vsd_miso} = '0;
      {ioctl_download, ioctl_index, motor, cas_dout, tape_adc, tape_adc_act} = '0;
      {dl_ddr_req, dl_ddr_rd, cas_ddr_rd, dl_ddr_addr, cas_ddr_addr} = '0;
      {check, done, kind, exp_word} = '0;
      test_id = 0;
      build_table();
      wait_cycles(16);
      reset = 1'b0;
      wait_cycles(4);
      for (int i = 0; i < n_rows; i++) begin
         test_id = i;
         apply_row(rows[i]);
      end
      done = 1'b1;
      wait_cycles(1);
      if (fail_count == 0 && tests_done == n_rows) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

   initial begin
      @(posedge timed_out);
      $display("Run stopped at the cycle limit before all tests finished");
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

/* testbench/msx_frame_checker.sv */
`timescale 1ns/1ps

module msx_frame_checker #(
   parameter int max_cycles = 1000
) (
   input  logic                                 clk21m,
   input  logic                                 check,
   input  logic                                 done,
   input  logic [2:0]                           kind,
   input  int                                   test_id,
   input  logic [63:0]                          exp_word,
   // Observed DUT outputs
   input  logic [31:0]                          prdata,
   input  logic                                 pready,
   input  logic                                 pslverr,
   input  logic                                 core_reset,
   input  logic [1:0]                           vga_sl,
   input  logic                                 hq2x,
   input  logic                                 scandoubler,
   input  logic [msx_frame_pkg::dim_w-1:0]      video_arx,
   input  logic [msx_frame_pkg::dim_w-1:0]      video_ary,
   input  logic [msx_frame_pkg::dim_w-1:0]      crop_size,
   input  logic [2:0]                           scale_sel,
   input  logic                                 sd_cs,
   input  logic                                 sd_sck,
   input  logic                                 sd_mosi,
   input  logic                                 spi_miso,
   input  logic                                 vsd_sel,
   input  logic                                 led_user,
   input  logic [1:0]                           led_disk,
   input  logic                                 rewind,
   input  logic                                 play,
   input  logic                                 cas_audio_in,
   input  logic [msx_frame_pkg::ddr_addr_w-1:0] ddr_addr,
   input  logic                                 ddr_rd,
   output int                                   fail_count,
   output int                                   tests_done,
   output logic                                 timed_out
);

   localparam logic [2:0] k_reg = 3'd0;
   localparam logic [2:0] k_vid = 3'd1;
   localparam logic [2:0] k_sd  = 3'd2;
   localparam logic [2:0] k_act = 3'd3;
   localparam logic [2:0] k_cas = 3'd4;
   localparam logic [2:0] k_ddr = 3'd5;

   int errors;
   int mismatches = 0;
   int cycle_count = 0;

   initial begin
      fail_count = 0;
      tests_done = 0;
   end

   function automatic string kind_name(input logic [2:0] k);
      case (k)
         k_reg:   return "register access";
         k_vid:   return "video control";
         k_sd:    return "sd routing";
         k_act:   return "sd activity";
         k_cas:   return "cassette control";
         default: return "ddr3 sharing";
      endcase
   endfunction

   task automatic compare(input string name, input logic [63:0] expected,
                          input logic [63:0] actual);
      if (actual !== expected) begin
         $display("ERROR test %0d: %s expected %0h got %0h", test_id, name, expected, actual);
         errors = errors + 1;
      end
   endtask

   // ===================================================================
   // Compare on the edge where the testbench raises check
   // ===================================================================
   always @(posedge clk21m) begin
      if (check) begin
         errors = 0;
         case (kind)
            k_reg: begin
               compare("pready", exp_word[34], pready);
               compare("core_reset", exp_word[33], core_reset);
               compare("pslverr", exp_word[32], pslverr);
               compare("prdata", exp_word[31:0], prdata);
            end
            k_vid: begin
               compare("scale_sel", exp_word[42:40], scale_sel);
               compare("vga_sl", exp_word[39:38], vga_sl);
               compare("hq2x", exp_word[37], hq2x);
               compare("scandoubler", exp_word[36], scandoubler);
               compare("crop_size", exp_word[35:24], crop_size);
               compare("video_arx", exp_word[23:12], video_arx);
               compare("video_ary", exp_word[11:0], video_ary);
            end
            k_sd: begin
               compare("led_user", exp_word[5], led_user);
               compare("vsd_sel", exp_word[4], vsd_sel);
               compare("sd_mosi", exp_word[3], sd_mosi);
               compare("sd_cs", exp_word[2], sd_cs);
               compare("sd_sck", exp_word[1], sd_sck);
               compare("spi_miso", exp_word[0], spi_miso);
            end
            k_act: compare("led_disk", exp_word[1:0], led_disk);
            k_cas: begin
               compare("rewind", exp_word[2], rewind);
               compare("play", exp_word[1], play);
               compare("cas_audio_in", exp_word[0], cas_audio_in);
            end
            k_ddr: begin
               compare("ddr_addr", exp_word[27:0], ddr_addr);
               compare("ddr_rd", exp_word[28], ddr_rd);
            end
            default: begin
               $display("Test %0d has an unknown kind %0d", test_id, kind);
               errors = 1;
            end
         endcase
         tests_done = tests_done + 1;
         mismatches = mismatches + errors;
         if (errors == 0) begin
            $display("test %0d %s: ok", test_id, kind_name(kind));
         end else begin
            fail_count = fail_count + 1;
            $display("test %0d %s: %0d mismatches", test_id, kind_name(kind), errors);
         end
      end
   end

   // Cycle budget for the whole run
   always @(posedge clk21m) begin
      cycle_count <= cycle_count + 1;
   end

   assign timed_out = (cycle_count >= max_cycles);

   initial begin
      @(posedge done);
      $display("Tests run %0d, failed %0d, signal mismatches %0d",
               tests_done, fail_count, mismatches);
   end

endmodule

/* rtl/msx_frame_top.sv */
`timescale 1ns/1ps

module msx_frame_top #(
   parameter logic [31:0] sd_act_cycles = msx_frame_pkg::sd_act_cycles_dflt
) (
   input  logic                                 clk21m,
   input  logic                                 reset,
   // APB settings port
   input  logic                                 psel,
   input  logic                                 penable,
   input  logic                                 pwrite,
   input  logic [msx_frame_pkg::apb_addr_w-1:0] paddr,
   input  logic [31:0]                          pwdata,
   output logic [31:0]                          prdata,
   output logic                                 pready,
   output logic                                 pslverr,
   // Video
   input  logic                                 forced_scandoubler,
   input  logic [msx_frame_pkg::dim_w-1:0]      hdmi_width,
   input  logic [msx_frame_pkg::dim_w-1:0]      hdmi_height,
   output logic [1:0]                           vga_sl,
   output logic                                 hq2x,
   output logic                                 scandoubler,
   output logic [msx_frame_pkg::dim_w-1:0]      video_arx,
   output logic [msx_frame_pkg::dim_w-1:0]      video_ary,
   output logic [msx_frame_pkg::dim_w-1:0]      crop_size,
   output logic [2:0]                           scale_sel,
   // SD card
   input  logic                                 img_mounted,
   input  logic [63:0]                          img_size,
   input  logic                                 spi_sck,
   input  logic                                 spi_mosi,
   input  logic                                 sd_miso,
   input  logic                                 vsd_miso,
   output logic                                 spi_miso,
   output logic                                 sd_cs,
   output logic                                 sd_sck,
   output logic                                 sd_mosi,
   output logic                                 vsd_sel,
   output logic                                 led_user,
   output logic [1:0]                           led_disk,
   // Cassette and DDR3
   input  logic                                 ioctl_download,
   input  logic [15:0]                          ioctl_index,
   input  logic                                 motor,
   input  logic                                 cas_dout,
   input  logic                                 tape_adc,
   input  logic                                 tape_adc_act,
   output logic                                 play,
   output logic                                 rewind,
   output logic                                 cas_audio_in,
   input  logic                                 dl_ddr_req,
   input  logic                                 dl_ddr_rd,
   input  logic                                 cas_ddr_rd,
   input  logic [msx_frame_pkg::ddr_addr_w-1:0] dl_ddr_addr,
   input  logic [msx_frame_pkg::ddr_addr_w-1:0] cas_ddr_addr,
   output logic [msx_frame_pkg::ddr_addr_w-1:0] ddr_addr,
   output logic                                 ddr_rd,
   output logic                                 core_reset
);

   logic [msx_frame_pkg::ar_w-1:0]    ar;
   logic [msx_frame_pkg::fx_w-1:0]    fx;
   logic [msx_frame_pkg::scale_w-1:0] scale;
   logic                              vcrop_en;
   logic                              tape_src_file;
   logic                              rewind_req;

   apb_status_regs apb_status_regs_inst (
      .clk21m(clk21m), .reset(reset),
      .psel(psel), .penable(penable), .pwrite(pwrite),
      .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
      .pready(pready), .pslverr(pslverr),
      .ar(ar), .fx(fx), .scale(scale), .vcrop_en(vcrop_en),
      .tape_src_file(tape_src_file), .rewind_req(rewind_req),
      .core_reset(core_reset)
   );

   // Blocks below run from the core reset
   video_scale_ctrl video_scale_ctrl_inst (
      .clk21m(clk21m), .reset(core_reset),
      .ar(ar), .fx(fx), .scale(scale), .vcrop_en(vcrop_en),
      .forced_scandoubler(forced_scandoubler),
      .hdmi_width(hdmi_width), .hdmi_height(hdmi_height),
      .vga_sl(vga_sl), .hq2x(hq2x), .scandoubler(scandoubler),
      .video_arx(video_arx), .video_ary(video_ary),
      .crop_size(crop_size), .scale_sel(scale_sel)
   );

   sd_activity #(.sd_act_cycles(sd_act_cycles)) sd_activity_inst (
      .clk21m(clk21m), .reset(core_reset),
      .img_mounted(img_mounted), .img_size(img_size),
      .spi_sck(spi_sck), .spi_mosi(spi_mosi),
      .sd_miso(sd_miso), .vsd_miso(vsd_miso), .spi_miso(spi_miso),
      .sd_cs(sd_cs), .sd_sck(sd_sck), .sd_mosi(sd_mosi),
      .vsd_sel(vsd_sel), .led_user(led_user), .led_disk(led_disk)
   );

   cassette_path cassette_path_inst (
      .clk21m(clk21m), .reset(core_reset),
      .ioctl_download(ioctl_download), .ioctl_index(ioctl_index),
      .motor(motor), .cas_dout(cas_dout),
      .tape_adc(tape_adc), .tape_adc_act(tape_adc_act),
      .tape_src_file(tape_src_file), .rewind_req(rewind_req),
      .play(play), .rewind(rewind), .cas_audio_in(cas_audio_in),
      .dl_ddr_req(dl_ddr_req), .dl_ddr_rd(dl_ddr_rd), .cas_ddr_rd(cas_ddr_rd),
      .dl_ddr_addr(dl_ddr_addr), .cas_ddr_addr(cas_ddr_addr),
      .ddr_addr(ddr_addr), .ddr_rd(ddr_rd)
   );

endmodule

/* rtl/cassette_path.sv */
`timescale 1ns/1ps

module cassette_path (
   input  logic                                 clk21m,
   input  logic                                 reset,
   input  logic                                 ioctl_download,
   input  logic [15:0]                          ioctl_index,
   input  logic                                 motor,
   input  logic                                 cas_dout,
   input  logic                                 tape_adc,
   input  logic                                 tape_adc_act,
   input  logic                                 tape_src_file,
   input  logic                                 rewind_req,
   output logic                                 play,
   output logic                                 rewind,
   output logic                                 cas_audio_in,
   input  logic                                 dl_ddr_req,
   input  logic                                 dl_ddr_rd,
   input  logic                                 cas_ddr_rd,
   input  logic [msx_frame_pkg::ddr_addr_w-1:0] dl_ddr_addr,
   input  logic [msx_frame_pkg::ddr_addr_w-1:0] cas_ddr_addr,
   output logic [msx_frame_pkg::ddr_addr_w-1:0] ddr_addr,
   output logic                                 ddr_rd
);

   logic is_cas;
   logic is_cas_q;
   logic cas_load;

   // ===================================================================
   // Cassette control
   // ===================================================================
   assign is_cas = ioctl_download & (ioctl_index[5:0] == msx_frame_pkg::cas_ioctl_index);

   // Image is ready once its download ends
   always_ff @(posedge clk21m) begin
      if (reset) begin
         is_cas_q <= 1'b0;
         cas_load <= 1'b0;
      end else begin
         is_cas_q <= is_cas;
         if (is_cas_q && !is_cas) begin
            cas_load <= 1'b1;
         end
      end
   end

   // Player runs while the motor relay is released
   assign play   = cas_load & ~motor;
   assign rewind = rewind_req | is_cas | reset;

   // Tape input from file or from the ADC receiver
   assign cas_audio_in = tape_src_file ? cas_dout : (tape_adc & tape_adc_act);

   // ===================================================================
   // DDR3 read port, downloader has priority
   // ===================================================================
   assign ddr_addr = dl_ddr_req ? dl_ddr_addr : cas_ddr_addr;
   assign ddr_rd   = dl_ddr_req ? dl_ddr_rd : cas_ddr_rd;

endmodule

/* rtl/sd_activity.sv */
`timescale 1ns/1ps

module sd_activity #(
   parameter logic [31:0] sd_act_cycles = msx_frame_pkg::sd_act_cycles_dflt
) (
   input  logic        clk21m,
   input  logic        reset,
   input  logic        img_mounted,
   input  logic [63:0] img_size,
   input  logic        spi_sck,
   input  logic        spi_mosi,
   input  logic        sd_miso,
   input  logic        vsd_miso,
   output logic        spi_miso,
   output logic        sd_cs,
   output logic        sd_sck,
   output logic        sd_mosi,
   output logic        vsd_sel,
   output logic        led_user,
   output logic [1:0]  led_disk
);

   logic [31:0] timer;
   logic        old_mosi;
   logic        old_miso;
   logic        sd_act;

   // Virtual card takes over once a nonempty image is mounted
   always_ff @(posedge clk21m) begin
      if (reset) begin
         vsd_sel <= 1'b0;
      end else if (img_mounted) begin
         vsd_sel <= |img_size;
      end
   end

   // Real card is idle while the virtual one is selected
   assign sd_cs    = vsd_sel;
   assign sd_sck   = spi_sck & ~vsd_sel;
   assign sd_mosi  = spi_mosi & ~vsd_sel;
   assign spi_miso = vsd_sel ? vsd_miso : sd_miso;

   // ===================================================================
   // Activity timer
   // ===================================================================
   always_ff @(posedge clk21m) begin
      old_mosi <= spi_mosi;
      old_miso <= spi_miso;
      if (reset) begin
         timer <= sd_act_cycles;
      end else if ((old_mosi ^ spi_mosi) || (old_miso ^ spi_miso)) begin
         timer <= '0;
      end else if (timer < sd_act_cycles) begin
         timer <= timer + 32'd1;
      end
   end

   assign sd_act   = (timer < sd_act_cycles);
   assign led_user = vsd_sel & sd_act;
   assign led_disk = {1'b1, ~vsd_sel & sd_act};

endmodule

/* rtl/video_scale_ctrl.sv */
`timescale 1ns/1ps

module video_scale_ctrl (
   input  logic                              clk21m,
   input  logic                              reset,
   input  logic [msx_frame_pkg::ar_w-1:0]    ar,
   input  logic [msx_frame_pkg::fx_w-1:0]    fx,
   input  logic [msx_frame_pkg::scale_w-1:0] scale,
   input  logic                              vcrop_en,
   input  logic                              forced_scandoubler,
   input  logic [msx_frame_pkg::dim_w-1:0]   hdmi_width,
   input  logic [msx_frame_pkg::dim_w-1:0]   hdmi_height,
   output logic [1:0]                        vga_sl,
   output logic                              hq2x,
   output logic                              scandoubler,
   output logic [msx_frame_pkg::dim_w-1:0]   video_arx,
   output logic [msx_frame_pkg::dim_w-1:0]   video_ary,
   output logic [msx_frame_pkg::dim_w-1:0]   crop_size,
   output logic [2:0]                        scale_sel
);

   logic                            sd_next;
   logic                            hq2x_next;
   logic [1:0]                      sl_next;
   logic                            wide_screen;
   logic                            wide;
   logic [msx_frame_pkg::dim_w-1:0] crop;
   logic [msx_frame_pkg::dim_w-1:0] arx_next;
   logic [msx_frame_pkg::dim_w-1:0] ary_next;

   assign sd_next   = (fx != '0) | forced_scandoubler;
   assign hq2x_next = (fx == 3'd1) || (fx == 3'd2);
   // CRT levels, deeper codes saturate at the strongest scanline
   assign sl_next   = (fx > 3'd3) ? 2'd2 : ((fx == 3'd3) ? 2'd1 : 2'd0);

   // Width at least 1.5 times the height, one bit wider to avoid overflow
   assign wide_screen = {1'b0, hdmi_width} >= ({1'b0, hdmi_height} + hdmi_height[11:1]);

   // ===================================================================
   // Crop table lookup
   // ===================================================================
   always_comb begin
      crop = '0;
      wide = 1'b0;
      if (!sd_next && wide_screen) begin
         case (hdmi_height)
            12'd480:  crop = msx_frame_pkg::crop_h480;
            12'd600:  crop = msx_frame_pkg::crop_h600;
            12'd720:  crop = msx_frame_pkg::crop_h720;
            12'd768:  crop = msx_frame_pkg::crop_h768;
            12'd800:  crop = msx_frame_pkg::crop_h800;
            12'd1080: crop = msx_frame_pkg::crop_h1080;
            12'd1200: crop = msx_frame_pkg::crop_h1200;
            12'd1440: crop = msx_frame_pkg::crop_h1440;
            12'd1536: crop = msx_frame_pkg::crop_h1536;
            default:  crop = '0;
         endcase
         wide = vcrop_en && (hdmi_height == 12'd600 || hdmi_height == 12'd800);
      end else if (!sd_next && hdmi_width >= 12'd1440) begin
         // 4:3 modes with large heights
         if (hdmi_height == 12'd1440) crop = msx_frame_pkg::crop_h1440;
         if (hdmi_height == 12'd1536) crop = msx_frame_pkg::crop_h1536;
      end
   end

   // Original aspect, or full screen and integer scaling codes
   always_comb begin
      arx_next = '0;
      ary_next = '0;
      if (ar == '0) begin
         arx_next = wide ? msx_frame_pkg::arx_wide : msx_frame_pkg::arx_orig_4_3;
         ary_next = msx_frame_pkg::ary_orig;
      end else begin
         arx_next[msx_frame_pkg::ar_w-1:0] = ar - 2'd1;
      end
   end

   always_ff @(posedge clk21m) begin
      if (reset) begin
         vga_sl      <= '0;
         hq2x        <= 1'b0;
         scandoubler <= forced_scandoubler;
         video_arx   <= '0;
         video_ary   <= '0;
         crop_size   <= '0;
         scale_sel   <= '0;
      end else begin
         vga_sl      <= sl_next;
         hq2x        <= hq2x_next;
         scandoubler <= sd_next;
         video_arx   <= arx_next;
         video_ary   <= ary_next;
         crop_size   <= vcrop_en ? crop : '0;
         scale_sel   <= {1'b0, scale};
      end
   end

endmodule

/* rtl/apb_status_regs.sv */
`timescale 1ns/1ps

module apb_status_regs (
   input  logic                                clk21m,
   input  logic                                reset,
   input  logic                                psel,
   input  logic                                penable,
   input  logic                                pwrite,
   input  logic [msx_frame_pkg::apb_addr_w-1:0] paddr,
   input  logic [31:0]                         pwdata,
   output logic [31:0]                         prdata,
   output logic                                pready,
   output logic                                pslverr,
   output logic [msx_frame_pkg::ar_w-1:0]      ar,
   output logic [msx_frame_pkg::fx_w-1:0]      fx,
   output logic [msx_frame_pkg::scale_w-1:0]   scale,
   output logic                                vcrop_en,
   output logic                                tape_src_file,
   output logic                                rewind_req,
   output logic                                core_reset
);

   logic access;
   logic hit_video;
   logic hit_tape;
   logic hit_ctrl;
   logic wr_ctrl_req;
   logic ctrl_pulse;

   assign access    = psel & penable;
   assign hit_video = (paddr == msx_frame_pkg::reg_video_addr);
   assign hit_tape  = (paddr == msx_frame_pkg::reg_tape_addr);
   assign hit_ctrl  = (paddr == msx_frame_pkg::reg_ctrl_addr);

   // No wait states
   assign pready  = 1'b1;
   assign pslverr = access & ~(hit_video | hit_tape | hit_ctrl);

   // Soft reset or eject written this cycle
   assign wr_ctrl_req = access & pwrite & hit_ctrl & (pwdata[0] | pwdata[1]);

   // Pulse bits read back as zero
   always_comb begin
      prdata = '0;
      if (hit_video) begin
         prdata[7:0] = {vcrop_en, scale, fx, ar};
      end else if (hit_tape) begin
         prdata[0] = tape_src_file;
      end
   end

   always_ff @(posedge clk21m) begin
      if (reset) begin
         ar            <= '0;
         fx            <= '0;
         scale         <= '0;
         vcrop_en      <= 1'b0;
         tape_src_file <= 1'b0;
         rewind_req    <= 1'b0;
         ctrl_pulse    <= 1'b0;
      end else begin
         rewind_req <= access & pwrite & hit_tape & pwdata[1];
         ctrl_pulse <= wr_ctrl_req;
         if (access && pwrite && hit_video) begin
            ar       <= pwdata[1:0];
            fx       <= pwdata[4:2];
            scale    <= pwdata[6:5];
            vcrop_en <= pwdata[7];
         end
         if (access && pwrite && hit_tape) begin
            tape_src_file <= pwdata[0];
         end
      end
   end

   // Core reset covers the request pulse and one cycle after it
   always_ff @(posedge clk21m) begin
      core_reset <= reset | wr_ctrl_req | ctrl_pulse;
   end

   a_penable_needs_psel : assert property (
      @(posedge clk21m) disable iff (reset) $rose(penable) |-> psel)
      else $error("penable rose without psel");

   a_addr_stable : assert property (
      @(posedge clk21m) disable iff (reset) psel && !penable |=> $stable(paddr))
      else $error("paddr changed between setup and access");

endmodule

/* rtl/msx_frame_pkg.sv */
package msx_frame_pkg;

   // ===================================================================
   // APB register map
   // ===================================================================
   localparam int apb_addr_w = 8;

   localparam logic [7:0] reg_video_addr = 8'h00;
   localparam logic [7:0] reg_tape_addr  = 8'h04;
   localparam logic [7:0] reg_ctrl_addr  = 8'h08;

   // Settings field widths
   localparam int fx_w    = 3;
   localparam int ar_w    = 2;
   localparam int scale_w = 2;

   // HDMI sizes and crop height
   localparam int dim_w = 12;

   // DDR3 byte address
   localparam int ddr_addr_w = 28;

   // Download slot of a CAS image
   localparam logic [5:0] cas_ioctl_index = 6'd5;

   // ===================================================================
   // Video aspect and crop constants
   // ===================================================================
   localparam logic [11:0] arx_orig_4_3 = 12'd400;
   localparam logic [11:0] arx_wide     = 12'd340;
   localparam logic [11:0] ary_orig     = 12'd300;

   // Visible lines kept for each supported HDMI height
   localparam logic [11:0] crop_h480  = 12'd240;
   localparam logic [11:0] crop_h600  = 12'd200;
   localparam logic [11:0] crop_h720  = 12'd240;
   localparam logic [11:0] crop_h768  = 12'd256;
   localparam logic [11:0] crop_h800  = 12'd200;
   localparam logic [11:0] crop_h1080 = 12'd216;
   localparam logic [11:0] crop_h1200 = 12'd240;
   localparam logic [11:0] crop_h1440 = 12'd240;
   localparam logic [11:0] crop_h1536 = 12'd256;

   // SD activity hold, in clk21m cycles
   localparam logic [31:0] sd_act_cycles_dflt = 32'd1_000_000;

endpackage
